// File: hdl/avmm1_pkg.sv
/* AVMM1 transfer package: data types, command and response word layouts,
   FIFO constants and the serializer state enum */
package avmm1_pkg;

	typedef logic [31:0] cmd_word_t;	// Outgoing command word
	typedef logic [15:0] rsp_word_t;	// Incoming response word
	typedef logic [9:0]  reg_addr_t;
	typedef logic [7:0]  avmm_data_t;
	typedef logic [8:0]  rsvd_in_t;
	typedef logic [2:0]  rsvd_out_t;
	typedef logic [1:0]  lane_pair_t;	// One beat on the outgoing lane

	// Command word fields
	localparam int CMD_VALID_BIT  = 0;
	localparam int CMD_WRITE_BIT  = 1;
	localparam int CMD_REQ_BIT    = 2;	// Request level, not the change
	localparam int CMD_READ_BIT   = 3;
	localparam int CMD_ADDR_LSB   = 4;
	localparam int CMD_RSVD_LSB   = 14;
	localparam int CMD_PARITY_BIT = 23;	// Even parity over the whole word
	localparam int CMD_WDATA_LSB  = 24;

	// Response word fields
	localparam int RSP_VALID_BIT  = 0;
	localparam int RSP_BUSY_BIT   = 1;
	localparam int RSP_RDATA_LSB  = 2;
	localparam int RSP_RDV_BIT    = 10;
	localparam int RSP_RSVD_LSB   = 11;
	localparam int RSP_PARITY_BIT = 14;
	localparam int RSP_VALID2_BIT = 15;	// Must match bit 0

	localparam int CMD_BEATS  = 16;	// Pairs per command word
	localparam int RSP_BITS   = 16;	// Bits per response word
	localparam int CMD_BEAT_W = $clog2(CMD_BEATS);
	localparam int RSP_CNT_W  = $clog2(RSP_BITS);
	typedef logic [CMD_BEAT_W-1:0] cmd_beat_t;
	typedef logic [RSP_CNT_W-1:0]  rsp_cnt_t;

	localparam int CMD_FIFO_DEPTH = 8;
	localparam int CMD_FIFO_PFULL = 6;	// Occupancy that raises partly-full
	localparam int CMD_FIFO_AW    = $clog2(CMD_FIFO_DEPTH);

	typedef enum logic {SER_IDLE, SER_SHIFT} ser_state_t;

endpackage

// File: hdl/avmm1_cmd_encoder.sv
/* Command encoder: request-change detection, command word packing, even parity */
module avmm1_cmd_encoder
	import avmm1_pkg::*;
(
	input  logic       avmm_clock_avmm_clk,
	input  logic       avmm_reset_avmm_rst_n,
	input  logic       read,
	input  logic       write,
	input  logic       request,
	input  reg_addr_t  reg_addr,
	input  avmm_data_t writedata,
	input  rsvd_in_t   reserved_in,
	output logic       cmd_push,
	output cmd_word_t  cmd_word
);

	logic      request_q;	// Last seen request level
	logic      request_chg;
	cmd_word_t word_base;	// Word with parity bit still clear

	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (!avmm_reset_avmm_rst_n)
		begin
			request_q <= 1'b0;
		end
		else
		begin
			request_q <= request;
		end
	end

	assign request_chg = (request != request_q);
	assign cmd_push = read | write | request_chg;	// Same cycle as the command

	always_comb
	begin
		word_base = '0;
		word_base[CMD_VALID_BIT] = 1'b1;	// Always set for a real command
		word_base[CMD_WRITE_BIT] = write;
		word_base[CMD_REQ_BIT] = request;
		word_base[CMD_READ_BIT] = read;
		word_base[CMD_ADDR_LSB +: $bits(reg_addr_t)] = reg_addr;
		word_base[CMD_RSVD_LSB +: $bits(rsvd_in_t)] = reserved_in;
		word_base[CMD_WDATA_LSB +: $bits(avmm_data_t)] = writedata;
	end

	// Parity bit evens out the XOR of all 32 bits
	always_comb
	begin
		cmd_word = word_base;
		cmd_word[CMD_PARITY_BIT] = ^word_base;
	end

endmodule

// File: hdl/avmm1_cmd_fifo.sv
/* Command FIFO: circular buffer of command words with registered full and
   partly-full flags, forced high during freeze */
module avmm1_cmd_fifo
	import avmm1_pkg::*;
(
	input  logic      avmm_clock_avmm_clk,
	input  logic      avmm_reset_avmm_rst_n,
	input  logic      push,
	input  cmd_word_t push_word,
	input  logic      pop,
	input  logic      nfrzdrv_in,
	output cmd_word_t head_word,
	output logic      empty,
	output logic      wr_full,
	output logic      wr_pfull
);

	cmd_word_t mem [CMD_FIFO_DEPTH];
	logic [CMD_FIFO_AW-1:0] wr_ptr;
	logic [CMD_FIFO_AW-1:0] rd_ptr;	// Wraps naturally, depth is a power of two
	logic [CMD_FIFO_AW:0]   count;
	logic [CMD_FIFO_AW:0]   count_next;
	logic push_ok;
	logic pop_ok;
	logic full_q;
	logic pfull_q;

	assign empty = (count == '0);
	assign push_ok = push & (count != (CMD_FIFO_AW+1)'(CMD_FIFO_DEPTH));	// Drop when full
	assign pop_ok = pop & ~empty;
	assign head_word = mem[rd_ptr];

	always_comb
	begin
		count_next = count;
		if (push_ok & ~pop_ok)
			count_next = count + 1'b1;
		else if (pop_ok & ~push_ok)
			count_next = count - 1'b1;
	end

	// Storage
	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (push_ok)
			mem[wr_ptr] <= push_word;
	end

	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (!avmm_reset_avmm_rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			full_q <= 1'b0;
			pfull_q <= 1'b0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
			// Flags follow the new occupancy one cycle later
			full_q <= (count_next == (CMD_FIFO_AW+1)'(CMD_FIFO_DEPTH));
			pfull_q <= (count_next >= (CMD_FIFO_AW+1)'(CMD_FIFO_PFULL));
		end
	end

	// Freeze (active low) reports the FIFO as full
	assign wr_full = nfrzdrv_in ? full_q : 1'b1;
	assign wr_pfull = nfrzdrv_in ? pfull_q : 1'b1;

endmodule

// File: hdl/avmm1_cmd_serializer.sv
/* Command serializer: pops command words and shifts them onto the two-bit lane */
module avmm1_cmd_serializer
	import avmm1_pkg::*;
(
	input  logic       avmm_clock_avmm_clk,
	input  logic       avmm_reset_avmm_rst_n,
	input  cmd_word_t  head_word,
	input  logic       empty,
	output logic       pop,
	output lane_pair_t lane_out
);

	ser_state_t state;
	cmd_beat_t  beat_cnt;
	cmd_word_t  shift_q;	// Lowest pair goes out first
	logic       last_beat;

	assign last_beat = (state == SER_SHIFT) && (beat_cnt == CMD_BEAT_W'(CMD_BEATS-1));
	// Next word is taken on the last beat so words follow with no gap
	assign pop = ~empty & ((state == SER_IDLE) | last_beat);

	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (pop)
			shift_q <= head_word;
		else if (state == SER_SHIFT)
			shift_q <= shift_q >> 2;
	end

	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (!avmm_reset_avmm_rst_n)
		begin
			state <= SER_IDLE;
			beat_cnt <= '0;
			lane_out <= 2'b00;
		end
		else
		begin
			lane_out <= (state == SER_SHIFT) ? shift_q[1:0] : 2'b00;	// Idle lane is 00
			case (state)
				SER_IDLE:
				begin
					beat_cnt <= '0;
					if (pop)
						state <= SER_SHIFT;
				end
				SER_SHIFT:
				begin
					beat_cnt <= beat_cnt + 1'b1;	// Wraps to 0 after last beat
					if (last_beat && !pop)
						state <= SER_IDLE;
				end
				default: state <= SER_IDLE;
			endcase
		end
	end

endmodule

// File: hdl/avmm1_rsp_deserializer.sv
/* Response deserializer: input flops, start detection and response word assembly */
module avmm1_rsp_deserializer
	import avmm1_pkg::*;
(
	input  logic      avmm_clock_avmm_clk,
	input  logic      avmm_reset_avmm_rst_n,
	input  logic      lane_in,
	output logic      rsp_strobe,
	output rsp_word_t rsp_word
);

	logic     in_q1;	// Newest bit
	logic     in_q2;	// Bit before it
	rsp_cnt_t beat_cnt;
	logic     active;

	// Start bit seen while idle, or a word already in progress
	assign active = (in_q1 & (beat_cnt == '0)) | (beat_cnt != '0);

	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (!avmm_reset_avmm_rst_n)
		begin
			in_q1 <= 1'b0;
			in_q2 <= 1'b0;
			beat_cnt <= '0;
			rsp_strobe <= 1'b0;
		end
		else
		begin
			in_q1 <= lane_in;
			in_q2 <= in_q1;
			beat_cnt <= active ? beat_cnt + 1'b1 : '0;
			rsp_strobe <= active & (beat_cnt == RSP_CNT_W'(RSP_BITS-1));	// Last pair in
		end
	end

	// Pair written on each odd count, low slot first
	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (beat_cnt[0])
			rsp_word[{beat_cnt[RSP_CNT_W-1:1], 1'b0} +: 2] <= {in_q1, in_q2};
	end

endmodule

// File: hdl/avmm1_rsp_decoder.sv
/* Response decoder: parity and valid checks, sticky error, busy and read data */
module avmm1_rsp_decoder
	import avmm1_pkg::*;
(
	input  logic       avmm_clock_avmm_clk,
	input  logic       avmm_reset_avmm_rst_n,
	input  logic       rsp_strobe,
	input  rsp_word_t  rsp_word,
	output logic       busy,
	output logic       readdatavalid,
	output avmm_data_t readdata,
	output rsvd_out_t  reserved_out,
	output logic       transfer_error
);

	rsp_word_t par_data;	// Word with the parity bit masked
	logic      parity_err;
	logic      valid_err;
	logic      rd_accept;

	always_comb
	begin
		par_data = rsp_word;
		par_data[RSP_PARITY_BIT] = 1'b0;
		parity_err = (^par_data) != rsp_word[RSP_PARITY_BIT];
	end

	assign valid_err = rsp_word[RSP_VALID_BIT] != rsp_word[RSP_VALID2_BIT];
	// Busy release and read data never come from the same word
	assign rd_accept = rsp_strobe & ~rsp_word[RSP_BUSY_BIT] & ~busy;

	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (!avmm_reset_avmm_rst_n)
		begin
			busy <= 1'b0;
			readdatavalid <= 1'b0;
			readdata <= '0;
			reserved_out <= '0;
			transfer_error <= 1'b0;
		end
		else
		begin
			if (rsp_strobe)
				busy <= rsp_word[RSP_BUSY_BIT];
			if (rd_accept)
			begin
				readdata <= rsp_word[RSP_RDATA_LSB +: $bits(avmm_data_t)];
				readdatavalid <= rsp_word[RSP_RDV_BIT];
				reserved_out <= rsp_word[RSP_RSVD_LSB +: $bits(rsvd_out_t)];
			end
			else
			begin
				readdata <= '0;	// One-cycle pulse only
				readdatavalid <= 1'b0;
				reserved_out <= '0;
			end
			// Sticky until reset
			transfer_error <= transfer_error | (rsp_strobe & (parity_err | valid_err));
		end
	end

endmodule

// File: hdl/avmm1_transfer.sv
/* AVMM1 transfer top: command encoder, FIFO and serializer out,
   response deserializer and decoder back */
module avmm1_transfer
	import avmm1_pkg::*;
(
	input  logic       avmm_clock_avmm_clk,
	input  logic       avmm_reset_avmm_rst_n,
	input  logic       remote_pld_avmm_read,
	input  logic       remote_pld_avmm_write,
	input  logic       remote_pld_avmm_request,
	input  reg_addr_t  remote_pld_avmm_reg_addr,
	input  avmm_data_t remote_pld_avmm_writedata,
	input  rsvd_in_t   remote_pld_avmm_reserved_in,
	input  logic       nfrzdrv_in,
	input  logic       aib_fabric_avmm_data_in,
	output lane_pair_t aib_fabric_avmm_data_out,
	output logic       remote_pld_avmm_busy,
	output avmm_data_t remote_pld_avmm_readdata,
	output logic       remote_pld_avmm_readdatavalid,
	output rsvd_out_t  remote_pld_avmm_reserved_out,
	output logic       pld_avmm_cmdfifo_wr_full,
	output logic       pld_avmm_cmdfifo_wr_pfull,
	output logic       avmm_transfer_error
);

	logic      cmd_push;
	cmd_word_t cmd_word;
	cmd_word_t head_word;
	logic      empty;
	logic      pop;
	logic      rsp_strobe;
	rsp_word_t rsp_word;

	avmm1_cmd_encoder i_avmm1_cmd_encoder (
		.avmm_clock_avmm_clk  (avmm_clock_avmm_clk),
		.avmm_reset_avmm_rst_n(avmm_reset_avmm_rst_n),
		.read                 (remote_pld_avmm_read),
		.write                (remote_pld_avmm_write),
		.request              (remote_pld_avmm_request),
		.reg_addr             (remote_pld_avmm_reg_addr),
		.writedata            (remote_pld_avmm_writedata),
		.reserved_in          (remote_pld_avmm_reserved_in),
		.cmd_push             (cmd_push),
		.cmd_word             (cmd_word)
	);

	avmm1_cmd_fifo i_avmm1_cmd_fifo (
		.avmm_clock_avmm_clk  (avmm_clock_avmm_clk),
		.avmm_reset_avmm_rst_n(avmm_reset_avmm_rst_n),
		.push                 (cmd_push),
		.push_word            (cmd_word),
		.pop                  (pop),
		.nfrzdrv_in           (nfrzdrv_in),
		.head_word            (head_word),
		.empty                (empty),
		.wr_full              (pld_avmm_cmdfifo_wr_full),	// Already freeze-forced
		.wr_pfull             (pld_avmm_cmdfifo_wr_pfull)
	);

	avmm1_cmd_serializer i_avmm1_cmd_serializer (
		.avmm_clock_avmm_clk  (avmm_clock_avmm_clk),
		.avmm_reset_avmm_rst_n(avmm_reset_avmm_rst_n),
		.head_word            (head_word),
		.empty                (empty),
		.pop                  (pop),
		.lane_out             (aib_fabric_avmm_data_out)
	);

	// Response path, one word per strobe straight into the decoder
	avmm1_rsp_deserializer i_avmm1_rsp_deserializer (
		.avmm_clock_avmm_clk  (avmm_clock_avmm_clk),
		.avmm_reset_avmm_rst_n(avmm_reset_avmm_rst_n),
		.lane_in              (aib_fabric_avmm_data_in),
		.rsp_strobe           (rsp_strobe),
		.rsp_word             (rsp_word)
	);

	avmm1_rsp_decoder i_avmm1_rsp_decoder (
		.avmm_clock_avmm_clk  (avmm_clock_avmm_clk),
		.avmm_reset_avmm_rst_n(avmm_reset_avmm_rst_n),
		.rsp_strobe           (rsp_strobe),
		.rsp_word             (rsp_word),
		.busy                 (remote_pld_avmm_busy),
		.readdatavalid        (remote_pld_avmm_readdatavalid),
		.readdata             (remote_pld_avmm_readdata),
		.reserved_out         (remote_pld_avmm_reserved_out),
		.transfer_error       (avmm_transfer_error)
	);

endmodule

// File: sim/avmm1_transfer_assert.sv
/* Concurrent assertions on the outgoing lane, read data pulse and sticky error */
module avmm1_transfer_assert
	import avmm1_pkg::*;
(
	input logic       avmm_clock_avmm_clk,
	input logic       avmm_reset_avmm_rst_n,
	input lane_pair_t aib_fabric_avmm_data_out,
	input logic       remote_pld_avmm_busy,
	input logic       remote_pld_avmm_readdatavalid,
	input logic       avmm_transfer_error
);

	// Sync reset clears the lane on the first reset edge
	lane_idle_in_reset: assert property (@(posedge avmm_clock_avmm_clk)
		!avmm_reset_avmm_rst_n |=> (aib_fabric_avmm_data_out == 2'b00))
		else $error("Outgoing lane not 00 during reset");

	rdv_not_while_busy: assert property (@(posedge avmm_clock_avmm_clk)
		disable iff (!avmm_reset_avmm_rst_n)
		$rose(remote_pld_avmm_readdatavalid) |-> !remote_pld_avmm_busy)
		else $error("Read data pulse while busy");

	// Only reset may clear it
	error_sticky: assert property (@(posedge avmm_clock_avmm_clk)
		disable iff (!avmm_reset_avmm_rst_n)
		!$fell(avmm_transfer_error))
		else $error("Transfer error fell outside reset");

endmodule

// File: sim/avmm1_transfer_tb.sv
/* Testbench for the AVMM1 transfer bridge: random commands, remote-side lane model,
   response traffic, scoreboard and result line */
module avmm1_transfer_tb
	import avmm1_pkg::*;
();

	logic       avmm_clock_avmm_clk;
	logic       avmm_reset_avmm_rst_n;
	logic       remote_pld_avmm_read;
	logic       remote_pld_avmm_write;
	logic       remote_pld_avmm_request;
	reg_addr_t  remote_pld_avmm_reg_addr;
	avmm_data_t remote_pld_avmm_writedata;
	rsvd_in_t   remote_pld_avmm_reserved_in;
	logic       nfrzdrv_in;
	logic       aib_fabric_avmm_data_in;
	lane_pair_t aib_fabric_avmm_data_out;
	logic       remote_pld_avmm_busy;
	avmm_data_t remote_pld_avmm_readdata;
	logic       remote_pld_avmm_readdatavalid;
	rsvd_out_t  remote_pld_avmm_reserved_out;
	logic       pld_avmm_cmdfifo_wr_full;
	logic       pld_avmm_cmdfifo_wr_pfull;
	logic       avmm_transfer_error;

	int          errors = 0;
	int          checks = 0;
	cmd_word_t   exp_cmds[$];	// Words the remote side should see, in order
	logic [10:0] exp_reads[$];	// {reserved_out, readdata} per expected pulse
	logic        req_model;	// Request level as the DUT last saw it
	logic        busy_model;
	int          cmd_seen = 0;
	int          beat = 0;
	logic        collecting = 1'b0;
	cmd_word_t   got_word;
	logic        err_prev = 1'b0;
	logic        rst_prev_low = 1'b0;
	logic        flags_watch = 1'b0;
	logic        saw_pfull;
	logic        saw_full;

	avmm1_transfer i_avmm1_transfer (.*);
	bind avmm1_transfer avmm1_transfer_assert i_avmm1_transfer_assert (.*);

	initial
	begin
		avmm_clock_avmm_clk = 1'b0;
		forever #4 avmm_clock_avmm_clk = ~avmm_clock_avmm_clk;	// Period 8
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("ERROR: %s", msg);
	endtask

	// Command word built straight from the bit layout
	function automatic cmd_word_t pack_cmd(input logic rd, input logic wr, input logic req,
		input reg_addr_t addr, input avmm_data_t wdata, input rsvd_in_t rsvd);
		cmd_word_t w;
		w = '0;
		w[0] = 1'b1;
		w[1] = wr;
		w[2] = req;
		w[3] = rd;
		w[13:4] = addr;
		w[22:14] = rsvd;
		w[31:24] = wdata;
		w[23] = ^w;	// Even parity over all 32 bits
		return w;
	endfunction

	function automatic rsp_word_t pack_rsp(input logic bsy, input logic rdv,
		input avmm_data_t data, input rsvd_out_t rsvd, input logic bad_par, input logic bad_copy);
		rsp_word_t w;
		w = '0;
		w[0] = 1'b1;	// Valid, doubles as start bit
		w[1] = bsy;
		w[9:2] = data;
		w[10] = rdv;
		w[13:11] = rsvd;
		w[15] = ~bad_copy;
		w[14] = (^w) ^ bad_par;
		return w;
	endfunction

	task automatic do_reset();
		@(posedge avmm_clock_avmm_clk);
		avmm_reset_avmm_rst_n <= 1'b0;
		remote_pld_avmm_read <= 1'b0;
		remote_pld_avmm_write <= 1'b0;
		remote_pld_avmm_request <= 1'b0;
		aib_fabric_avmm_data_in <= 1'b0;
		repeat (5) @(posedge avmm_clock_avmm_clk);
		avmm_reset_avmm_rst_n <= 1'b1;
		exp_cmds.delete();
		exp_reads.delete();
		req_model = 1'b0;	// Request flop clears in reset
		busy_model = 1'b0;
	endtask

	// One command with random payload, held for a single edge, only while not full
	task automatic issue_cmd(input logic rd, input logic wr, input logic req);
		int wait_cnt;
		reg_addr_t addr;
		avmm_data_t wdata;
		rsvd_in_t rsvd;
		wait_cnt = 0;
		addr = reg_addr_t'($urandom);
		wdata = avmm_data_t'($urandom);
		rsvd = rsvd_in_t'($urandom);
		@(negedge avmm_clock_avmm_clk);
		while (pld_avmm_cmdfifo_wr_full && wait_cnt < 400)
		begin
			@(negedge avmm_clock_avmm_clk);
			wait_cnt++;
		end
		if (pld_avmm_cmdfifo_wr_full)
			report_problem("command FIFO stayed full, command not issued");
		else
		begin
			@(posedge avmm_clock_avmm_clk);
			remote_pld_avmm_read <= rd;
			remote_pld_avmm_write <= wr;
			remote_pld_avmm_request <= req;
			remote_pld_avmm_reg_addr <= addr;
			remote_pld_avmm_writedata <= wdata;
			remote_pld_avmm_reserved_in <= rsvd;
			if (rd | wr | (req != req_model))
				exp_cmds.push_back(pack_cmd(rd, wr, req, addr, wdata, rsvd));
			req_model = req;
			@(posedge avmm_clock_avmm_clk);
			remote_pld_avmm_read <= 1'b0;
			remote_pld_avmm_write <= 1'b0;
		end
	endtask

	task automatic wait_cmds_drained();
		int wait_cnt;
		wait_cnt = 0;
		while (exp_cmds.size() != 0 && wait_cnt < 3000)
		begin
			@(negedge avmm_clock_avmm_clk);
			wait_cnt++;
		end
		if (exp_cmds.size() != 0)
			report_problem("expected command words never appeared on the lane");
	endtask

	// Shift a response in lowest bit first, then idle; outputs settle 18 edges after start
	task automatic send_rsp(input rsp_word_t w);
		for (int i = 0; i < RSP_BITS; i++)
		begin
			@(posedge avmm_clock_avmm_clk);
			aib_fabric_avmm_data_in <= w[i];
		end
		@(posedge avmm_clock_avmm_clk);
		aib_fabric_avmm_data_in <= 1'b0;
		if (!w[1] && !busy_model && w[10])
			exp_reads.push_back({w[13:11], w[9:2]});
		busy_model = w[1];
		repeat (2) @(posedge avmm_clock_avmm_clk);
		@(negedge avmm_clock_avmm_clk);
		check_value("busy", busy_model, remote_pld_avmm_busy);
	endtask

	// Remote side: a pair with bit 0 set while idle starts a 16-pair word
	always @(negedge avmm_clock_avmm_clk)
	begin
		if (!avmm_reset_avmm_rst_n)
		begin
			collecting = 1'b0;
			beat = 0;
		end
		else if (collecting || aib_fabric_avmm_data_out[0])
		begin
			collecting = 1'b1;
			got_word[beat*2 +: 2] = aib_fabric_avmm_data_out;
			if (beat == CMD_BEATS - 1)
			begin
				collecting = 1'b0;
				beat = 0;
				cmd_seen++;
				check_value("cmd parity", 0, ^got_word);
				if (exp_cmds.size() == 0)
					report_problem("command word on the lane with none expected");
				else
					check_value("cmd word", exp_cmds.pop_front(), got_word);
			end
			else
				beat++;
		end
	end

	// Read data scoreboard and output rules
	always @(negedge avmm_clock_avmm_clk)
	begin
		if (avmm_reset_avmm_rst_n)
		begin
			if (remote_pld_avmm_readdatavalid)
			begin
				if (remote_pld_avmm_busy)
					report_problem("readdatavalid high while busy");
				if (exp_reads.size() == 0)
					report_problem("read data pulse with none expected");
				else
				begin
					check_value("readdata", exp_reads[0][7:0], remote_pld_avmm_readdata);
					check_value("reserved_out", exp_reads[0][10:8], remote_pld_avmm_reserved_out);
					void'(exp_reads.pop_front());
				end
			end
			if (err_prev && !avmm_transfer_error)
				report_problem("transfer error cleared without reset");
		end
		else if (rst_prev_low && aib_fabric_avmm_data_out !== 2'b00)
			report_problem("outgoing lane not idle during reset");
		err_prev = avmm_transfer_error;
		rst_prev_low = !avmm_reset_avmm_rst_n;
		if (flags_watch)
		begin
			saw_pfull = saw_pfull | pld_avmm_cmdfifo_wr_pfull;
			if (pld_avmm_cmdfifo_wr_full && !saw_pfull)
				report_problem("wr_full raised before wr_pfull");
			saw_full = saw_full | pld_avmm_cmdfifo_wr_full;
		end
	end

	initial
	begin
		int seen_before;
		logic rd;
		avmm_reset_avmm_rst_n = 1'b0;
		remote_pld_avmm_read = 1'b0;
		remote_pld_avmm_write = 1'b0;
		remote_pld_avmm_request = 1'b0;
		remote_pld_avmm_reg_addr = '0;
		remote_pld_avmm_writedata = '0;
		remote_pld_avmm_reserved_in = '0;
		nfrzdrv_in = 1'b1;	// Not frozen
		aib_fabric_avmm_data_in = 1'b0;
		void'($urandom(32'h25249f2e));
		do_reset();

		// Random reads and writes
		repeat (40)
		begin
			rd = $urandom_range(1, 0);
			issue_cmd(rd, ~rd, req_model);
		end
		wait_cmds_drained();

		// Request toggle gives one word, steady level gives none
		issue_cmd(1'b0, 1'b0, ~req_model);
		wait_cmds_drained();
		seen_before = cmd_seen;
		repeat (60) @(posedge avmm_clock_avmm_clk);
		check_value("words with steady request", seen_before, cmd_seen);

		// Burst fills the FIFO, then freeze forces both flags
		saw_pfull = 1'b0;
		saw_full = 1'b0;
		flags_watch = 1'b1;
		repeat (24) issue_cmd(1'b0, 1'b1, req_model);
		wait_cmds_drained();
		flags_watch = 1'b0;
		check_value("wr_pfull seen", 1, saw_pfull);
		check_value("wr_full seen", 1, saw_full);
		@(negedge avmm_clock_avmm_clk);
		check_value("wr_full after drain", 0, pld_avmm_cmdfifo_wr_full);
		@(posedge avmm_clock_avmm_clk);
		nfrzdrv_in <= 1'b0;
		@(negedge avmm_clock_avmm_clk);
		check_value("wr_full frozen", 1, pld_avmm_cmdfifo_wr_full);
		check_value("wr_pfull frozen", 1, pld_avmm_cmdfifo_wr_pfull);
		@(posedge avmm_clock_avmm_clk);
		nfrzdrv_in <= 1'b1;
		@(negedge avmm_clock_avmm_clk);
		check_value("wr_full unfrozen", 0, pld_avmm_cmdfifo_wr_full);

		// Read responses, then busy holding off the pulse
		repeat (12) send_rsp(pack_rsp(0, 1, $urandom, $urandom, 0, 0));
		send_rsp(pack_rsp(1, 1, $urandom, $urandom, 0, 0));
		send_rsp(pack_rsp(1, 1, $urandom, $urandom, 0, 0));
		send_rsp(pack_rsp(0, 1, $urandom, $urandom, 0, 0));	// Releases busy, no pulse
		send_rsp(pack_rsp(0, 1, $urandom, $urandom, 0, 0));
		@(negedge avmm_clock_avmm_clk);
		check_value("read pulses left", 0, exp_reads.size());
		check_value("error after clean traffic", 0, avmm_transfer_error);

		// Bad parity, then a valid copy mismatch after a fresh reset
		send_rsp(pack_rsp(0, 0, $urandom, $urandom, 1, 0));
		check_value("error on bad parity", 1, avmm_transfer_error);
		send_rsp(pack_rsp(0, 1, $urandom, $urandom, 0, 0));
		check_value("error held", 1, avmm_transfer_error);
		do_reset();
		@(negedge avmm_clock_avmm_clk);
		check_value("error after reset", 0, avmm_transfer_error);
		send_rsp(pack_rsp(0, 0, $urandom, $urandom, 0, 1));
		check_value("error on valid copy", 1, avmm_transfer_error);
		send_rsp(pack_rsp(0, 1, $urandom, $urandom, 0, 0));
		check_value("error held", 1, avmm_transfer_error);
		@(negedge avmm_clock_avmm_clk);
		check_value("read pulses left", 0, exp_reads.size());

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: avmm1_transfer.f
hdl/avmm1_pkg.sv
hdl/avmm1_cmd_encoder.sv
hdl/avmm1_cmd_fifo.sv
hdl/avmm1_cmd_serializer.sv
hdl/avmm1_rsp_deserializer.sv
hdl/avmm1_rsp_decoder.sv
hdl/avmm1_transfer.sv
sim/avmm1_transfer_assert.sv
sim/avmm1_transfer_tb.sv

// File: Bender.yml
package:
  name: avmm1_transfer

sources:
  - files:
      - hdl/avmm1_pkg.sv
      - hdl/avmm1_cmd_encoder.sv
      - hdl/avmm1_cmd_fifo.sv
      - hdl/avmm1_cmd_serializer.sv
      - hdl/avmm1_rsp_deserializer.sv
      - hdl/avmm1_rsp_decoder.sv
      - hdl/avmm1_transfer.sv
  - target: simulation
    files:
      - sim/avmm1_transfer_assert.sv
      - sim/avmm1_transfer_tb.sv
